// File: src/SynthPkg.sv
//------------------------------
// Shared widths, register map and state types of the synth audio block
// Each RTL module imports this package inside its body
//------------------------------
package SynthPkg;

	// Data path widths
	localparam int cSampleWidth  = 16;
	localparam int cVolumeWidth  = 15;
	localparam int cApbAdrsWidth = 8;
	localparam int cApbDataWidth = 32;

	//------------------------------
	// Register offsets
	//------------------------------
	// CTRL    bit 0 enable and bits 7:4 MIDI channel
	// VOLUME  bits 14:0 amplitude
	// STATUS  bits 6:0 note, bit 8 gate, bit 9 sticky framing error
	localparam logic [cApbAdrsWidth-1:0] cAdrsCtrl   = 8'h00;
	localparam logic [cApbAdrsWidth-1:0] cAdrsVolume = 8'h04;
	localparam logic [cApbAdrsWidth-1:0] cAdrsStatus = 8'h08;

	// MIDI status nibble
	typedef enum logic [3:0] {
		cmdOther   = 4'h0,
		cmdNoteOff = 4'h8,
		cmdNoteOn  = 4'h9
	} tMidiCmd;

	// Parser position inside a note message
	typedef enum logic [1:0] {
		psIdle,
		psKey,
		psVelocity
	} tParseState;

	// Serial receiver states
	typedef enum logic [1:0] {
		rsIdle,
		rsStart,
		rsData,
		rsStop
	} tRxState;

endpackage

// File: src/MidiRx.sv
//------------------------------
// MIDI serial receiver, 8N1 at pMidiClkPerBit clocks per bit
// Pulses oRxValid with the byte in the middle of the stop bit
// or oFrameErr when the stop bit is low
//------------------------------
module MidiRx #(
	parameter int pMidiClkPerBit = 32
) (
	input  logic       iMCLK,
	input  logic       qlocked,
	input  logic       iMidi,
	output logic [7:0] oRxByte,
	output logic       oRxValid,
	output logic       oFrameErr
);
	import SynthPkg::*;

	localparam int lpCntWidth = $clog2(pMidiClkPerBit);
	// Start bit center less the sync and edge detect delay
	localparam logic [lpCntWidth-1:0] lpHalfCnt = lpCntWidth'(pMidiClkPerBit / 2 - 4);
	localparam logic [lpCntWidth-1:0] lpFullCnt = lpCntWidth'(pMidiClkPerBit - 1);

	logic [2:0]            rSync;
	logic                  qFall;
	tRxState               rState;
	logic [lpCntWidth-1:0] rCycleCnt;
	logic [2:0]            rBitCnt;
	logic [7:0]            rShift;

	// Two sync flops and one more for the edge detect
	always_ff @(posedge iMCLK, negedge qlocked)
	begin
		if (!qlocked)
			rSync <= 3'b111;
		else
			rSync <= {rSync[1:0], iMidi};
	end

	assign qFall   = rSync[2] && !rSync[1];
	assign oRxByte = rShift;

	//------------------------------
	// Receive FSM
	//------------------------------
	always_ff @(posedge iMCLK, negedge qlocked)
	begin
		if (!qlocked)
		begin
			rState    <= rsIdle;
			rCycleCnt <= '0;
			rBitCnt   <= '0;
			oRxValid  <= 1'b0;
			oFrameErr <= 1'b0;
		end
		else
		begin
			oRxValid  <= 1'b0;
			oFrameErr <= 1'b0;
			case (rState)
				rsIdle:
				begin
					rCycleCnt <= '0;
					rBitCnt   <= '0;
					if (qFall)
						rState <= rsStart;
				end
				rsStart:
				begin
					if (rCycleCnt == lpHalfCnt)
					begin
						rCycleCnt <= '0;
						// Line back high at the center means a glitch
						rState    <= rSync[1] ? rsIdle : rsData;
					end
					else
						rCycleCnt <= rCycleCnt + 1'b1;
				end
				rsData:
				begin
					if (rCycleCnt == lpFullCnt)
					begin
						rCycleCnt <= '0;
						rBitCnt   <= rBitCnt + 1'b1;
						if (rBitCnt == 3'd7)
							rState <= rsStop;
					end
					else
						rCycleCnt <= rCycleCnt + 1'b1;
				end
				rsStop:
				begin
					if (rCycleCnt == lpFullCnt)
					begin
						oRxValid  <= rSync[1];
						oFrameErr <= !rSync[1];
						rState    <= rsIdle;
					end
					else
						rCycleCnt <= rCycleCnt + 1'b1;
				end
				default:
					rState <= rsIdle;
			endcase
		end
	end

	// LSB first
	always_ff @(posedge iMCLK, negedge qlocked)
	begin
		if (!qlocked)
			rShift <= '0;
		else if (rState == rsData && rCycleCnt == lpFullCnt)
			rShift <= {rSync[1], rShift[7:1]};
	end

endmodule

// File: src/MidiParser.sv
//------------------------------
// MIDI byte parser for note on and note off on one channel
// Keeps running status and a single held note with its gate
//------------------------------
module MidiParser (
	input  logic       iMCLK,
	input  logic       qlocked,
	input  logic [7:0] iRxByte,
	input  logic       iRxValid,
	input  logic [3:0] iChannel,
	output logic       oGate,
	output logic [6:0] oNote
);
	import SynthPkg::*;

	tMidiCmd    rCmd;
	logic [3:0] rCmdChan;
	tParseState rState;
	logic [6:0] rKey;
	tMidiCmd    qCmdDec;
	logic       qRealTime;
	logic       qMatch;

	always_comb
	begin
		case (iRxByte[7:4])
			4'h8:    qCmdDec = cmdNoteOff;
			4'h9:    qCmdDec = cmdNoteOn;
			default: qCmdDec = cmdOther;
		endcase
		// 0xF8 to 0xFF
		qRealTime = (iRxByte[7:3] == 5'b11111);
		qMatch    = (rCmdChan == iChannel);
	end

	//------------------------------
	// Status and data bytes
	//------------------------------
	always_ff @(posedge iMCLK, negedge qlocked)
	begin
		if (!qlocked)
		begin
			rCmd     <= cmdOther;
			rCmdChan <= '0;
			rState   <= psIdle;
			rKey     <= '0;
			oGate    <= 1'b0;
			oNote    <= '0;
		end
		else if (iRxValid)
		begin
			if (iRxByte[7])
			begin
				// Realtime bytes may arrive mid message and are not status
				if (!qRealTime)
				begin
					rCmd     <= qCmdDec;
					rCmdChan <= iRxByte[3:0];
					rState   <= (qCmdDec == cmdOther) ? psIdle : psKey;
				end
			end
			else
			begin
				case (rState)
					psKey:
					begin
						rKey   <= iRxByte[6:0];
						rState <= psVelocity;
					end
					psVelocity:
					begin
						// Next data byte is a key again under running status
						rState <= psKey;
						if (qMatch)
						begin
							if (rCmd == cmdNoteOn && iRxByte[6:0] != 7'd0)
							begin
								oGate <= 1'b1;
								oNote <= rKey;
							end
							else if (rCmd == cmdNoteOn)
								oGate <= 1'b0;
							else if (rKey == oNote)
								oGate <= 1'b0;
						end
					end
					// Data of an ignored message
					default:
						rState <= psIdle;
				endcase
			end
		end
	end

endmodule

// File: src/SynthCsr.sv
//------------------------------
// APB register block with one wait state per access
// Holds CTRL and VOLUME and reports note, gate and framing error
//------------------------------
module SynthCsr (
	input  logic                               iMCLK,
	input  logic                               qlocked,
	input  logic                               PSEL,
	input  logic                               PENABLE,
	input  logic                               PWRITE,
	input  logic [SynthPkg::cApbAdrsWidth-1:0] PADDR,
	input  logic [SynthPkg::cApbDataWidth-1:0] PWDATA,
	output logic [SynthPkg::cApbDataWidth-1:0] PRDATA,
	output logic                               PREADY,
	output logic                               PSLVERR,
	input  logic                               iGate,
	input  logic [6:0]                         iNote,
	input  logic                               iFrameErr,
	output logic                               oEnable,
	output logic [3:0]                         oChannel,
	output logic [SynthPkg::cVolumeWidth-1:0]  oVolume
);
	import SynthPkg::*;

	logic                     qAccess;
	logic                     qWrite;
	logic                     qHit;
	logic [cApbDataWidth-1:0] qRdata;
	logic                     rFrameErr;

	//------------------------------
	// Address decode and read mux
	//------------------------------
	always_comb
	begin
		qAccess = PSEL && PENABLE;
		qWrite  = qAccess && PWRITE && PREADY;
		qHit    = 1'b1;
		qRdata  = '0;
		case (PADDR)
			cAdrsCtrl:
			begin
				qRdata[0]   = oEnable;
				qRdata[7:4] = oChannel;
			end
			cAdrsVolume:
				qRdata[cVolumeWidth-1:0] = oVolume;
			cAdrsStatus:
			begin
				qRdata[6:0] = iNote;
				qRdata[8]   = iGate;
				qRdata[9]   = rFrameErr;
			end
			default:
				qHit = 1'b0;
		endcase
	end

	// Ready comes in the second access cycle and lasts one cycle
	always_ff @(posedge iMCLK, negedge qlocked)
	begin
		if (!qlocked)
		begin
			PREADY  <= 1'b0;
			PSLVERR <= 1'b0;
			PRDATA  <= '0;
		end
		else
		begin
			PREADY  <= qAccess && !PREADY;
			PSLVERR <= qAccess && !PREADY && !qHit;
			if (qAccess && !PREADY)
				PRDATA <= qRdata;
		end
	end

	//------------------------------
	// Control registers
	//------------------------------
	always_ff @(posedge iMCLK, negedge qlocked)
	begin
		if (!qlocked)
		begin
			oEnable   <= 1'b0;
			oChannel  <= '0;
			oVolume   <= '0;
			rFrameErr <= 1'b0;
		end
		else
		begin
			if (qWrite && PADDR == cAdrsCtrl)
			begin
				oEnable  <= PWDATA[0];
				oChannel <= PWDATA[7:4];
			end
			if (qWrite && PADDR == cAdrsVolume)
				oVolume <= PWDATA[cVolumeWidth-1:0];
			// A new error beats a clear in the same cycle
			if (iFrameErr)
				rFrameErr <= 1'b1;
			else if (qWrite && PADDR == cAdrsStatus && PWDATA[9])
				rFrameErr <= 1'b0;
		end
	end

endmodule

// File: src/ToneGen.sv
//------------------------------
// Square wave voice from a 24-bit phase accumulator
// Phase steps once per sample request by the note's increment
//------------------------------
module ToneGen (
	input  logic                              iMCLK,
	input  logic                              qlocked,
	input  logic                              iSampleReq,
	input  logic                              iGate,
	input  logic [6:0]                        iNote,
	input  logic                              iEnable,
	input  logic [SynthPkg::cVolumeWidth-1:0] iVolume,
	output logic [SynthPkg::cSampleWidth-1:0] oSample
);
	import SynthPkg::*;

	localparam int lpPhaseWidth = 24;

	logic [lpPhaseWidth-1:0] rPhase;
	logic [lpPhaseWidth-1:0] qStep;
	logic [3:0]              qSemitone;
	logic [3:0]              qOctave;
	logic [13:0]             qBase;
	logic [cSampleWidth-1:0] qMag;
	logic                    qActive;

	//------------------------------
	// Phase increment
	//------------------------------
	always_comb
	begin
		qSemitone = 4'(iNote % 7'd12);
		qOctave   = 4'(iNote / 7'd12);
		// Lowest octave, 8192 times 2 to the n/12
		case (qSemitone)
			4'd0:    qBase = 14'd8192;
			4'd1:    qBase = 14'd8679;
			4'd2:    qBase = 14'd9195;
			4'd3:    qBase = 14'd9742;
			4'd4:    qBase = 14'd10321;
			4'd5:    qBase = 14'd10935;
			4'd6:    qBase = 14'd11585;
			4'd7:    qBase = 14'd12274;
			4'd8:    qBase = 14'd13004;
			4'd9:    qBase = 14'd13777;
			4'd10:   qBase = 14'd14596;
			default: qBase = 14'd15464;
		endcase
		// Note 127 still fits in 24 bits
		qStep   = lpPhaseWidth'(qBase) << qOctave;
		qActive = iGate && iEnable;
	end

	always_ff @(posedge iMCLK, negedge qlocked)
	begin
		if (!qlocked)
			rPhase <= '0;
		else if (!qActive)
			// Every note starts on the positive half
			rPhase <= '0;
		else if (iSampleReq)
			rPhase <= rPhase + qStep;
	end

	// Sample follows the phase register one cycle after the request
	always_comb
	begin
		qMag = cSampleWidth'(iVolume);
		if (!qActive)
			oSample = '0;
		else if (rPhase[lpPhaseWidth-1])
			oSample = -qMag;
		else
			oSample = qMag;
	end

endmodule

// File: src/I2sTx.sv
//------------------------------
// I2S transmitter for 16-bit stereo
// BCLK is iMCLK over 2*pBclkHalf and a frame is 32 BCLK periods
//------------------------------
module I2sTx #(
	parameter int pBclkHalf = 4
) (
	input  logic                              iMCLK,
	input  logic                              qlocked,
	input  logic [SynthPkg::cSampleWidth-1:0] iSample,
	output logic                              oSampleReq,
	output logic                              oI2sBclk,
	output logic                              oI2sLrclk,
	output logic                              oI2sSdata
);
	import SynthPkg::*;

	localparam int lpDivWidth  = (pBclkHalf > 1) ? $clog2(pBclkHalf) : 1;
	localparam int lpSlotWidth = $clog2(2 * cSampleWidth);
	localparam logic [lpDivWidth-1:0]  lpDivLast = lpDivWidth'(pBclkHalf - 1);
	localparam logic [lpSlotWidth-1:0] lpReqSlot = lpSlotWidth'(2 * cSampleWidth - 2);

	logic [lpDivWidth-1:0]     rDivCnt;
	logic [lpSlotWidth-1:0]    rSlot;
	logic [lpSlotWidth-1:0]    qNextSlot;
	logic [2*cSampleWidth-1:0] rShift;
	logic                      qToggle;
	logic                      qFall;

	always_comb
	begin
		qToggle   = (rDivCnt == lpDivLast);
		qFall     = qToggle && oI2sBclk;
		qNextSlot = rSlot + 1'b1;
	end

	// BCLK divider
	always_ff @(posedge iMCLK, negedge qlocked)
	begin
		if (!qlocked)
		begin
			rDivCnt  <= '0;
			oI2sBclk <= 1'b0;
		end
		else if (qToggle)
		begin
			rDivCnt  <= '0;
			oI2sBclk <= !oI2sBclk;
		end
		else
			rDivCnt <= rDivCnt + 1'b1;
	end

	//------------------------------
	// Everything moves on the BCLK falling edge
	//------------------------------
	always_ff @(posedge iMCLK, negedge qlocked)
	begin
		if (!qlocked)
		begin
			rSlot      <= '0;
			rShift     <= '0;
			oI2sLrclk  <= 1'b0;
			oI2sSdata  <= 1'b0;
			oSampleReq <= 1'b0;
		end
		else
		begin
			oSampleReq <= qFall && (qNextSlot == lpReqSlot + 1'b1);
			if (qFall)
			begin
				rSlot     <= qNextSlot;
				oI2sLrclk <= qNextSlot[lpSlotWidth-1];
				// Top bit goes out one BCLK after the LRCLK change
				oI2sSdata <= rShift[2*cSampleWidth-1];
				if (qNextSlot == '0)
					rShift <= {iSample, iSample};
				else
					rShift <= rShift << 1;
			end
		end
	end

endmodule

// File: src/SynthTop.sv
//------------------------------
// Top of the synth audio block
// MIDI in, APB register port and I2S out on the single iMCLK domain
//------------------------------
module SynthTop #(
	parameter int pMidiClkPerBit = 32,
	parameter int pBclkHalf      = 4
) (
	input  logic                               iMCLK,
	input  logic                               qlocked,
	input  logic                               iMidi,
	input  logic                               PSEL,
	input  logic                               PENABLE,
	input  logic                               PWRITE,
	input  logic [SynthPkg::cApbAdrsWidth-1:0] PADDR,
	input  logic [SynthPkg::cApbDataWidth-1:0] PWDATA,
	output logic [SynthPkg::cApbDataWidth-1:0] PRDATA,
	output logic                               PREADY,
	output logic                               PSLVERR,
	output logic                               oI2sBclk,
	output logic                               oI2sLrclk,
	output logic                               oI2sSdata
);
	import SynthPkg::*;

	logic [7:0]              wRxByte;
	logic                    wRxValid;
	logic                    wRxFrameErr;
	logic [3:0]              wChannel;
	logic                    wEnable;
	logic [cVolumeWidth-1:0] wVolume;
	logic                    wGate;
	logic [6:0]              wNote;
	logic                    wSampleReq;
	logic [cSampleWidth-1:0] wSample;

	//------------------------------
	// MIDI input path
	//------------------------------
	MidiRx #(
		.pMidiClkPerBit(pMidiClkPerBit)
	) MidiRx (
		.iMCLK(iMCLK),        .qlocked(qlocked),
		.iMidi(iMidi),
		.oRxByte(wRxByte),    .oRxValid(wRxValid),
		.oFrameErr(wRxFrameErr)
	);

	MidiParser MidiParser (
		.iMCLK(iMCLK),        .qlocked(qlocked),
		.iRxByte(wRxByte),    .iRxValid(wRxValid),
		.iChannel(wChannel),
		.oGate(wGate),        .oNote(wNote)
	);

	// Registers
	SynthCsr SynthCsr (
		.iMCLK(iMCLK),        .qlocked(qlocked),
		.PSEL(PSEL),          .PENABLE(PENABLE),
		.PWRITE(PWRITE),      .PADDR(PADDR),
		.PWDATA(PWDATA),      .PRDATA(PRDATA),
		.PREADY(PREADY),      .PSLVERR(PSLVERR),
		.iGate(wGate),        .iNote(wNote),
		.iFrameErr(wRxFrameErr),
		.oEnable(wEnable),    .oChannel(wChannel),
		.oVolume(wVolume)
	);

	//------------------------------
	// Audio path
	//------------------------------
	ToneGen ToneGen (
		.iMCLK(iMCLK),        .qlocked(qlocked),
		.iSampleReq(wSampleReq),
		.iGate(wGate),        .iNote(wNote),
		.iEnable(wEnable),    .iVolume(wVolume),
		.oSample(wSample)
	);

	I2sTx #(
		.pBclkHalf(pBclkHalf)
	) I2sTx (
		.iMCLK(iMCLK),        .qlocked(qlocked),
		.iSample(wSample),    .oSampleReq(wSampleReq),
		.oI2sBclk(oI2sBclk),  .oI2sLrclk(oI2sLrclk),
		.oI2sSdata(oI2sSdata)
	);

endmodule

// File: tests/ClockGen.sv
//------------------------------
// Testbench clock and reset source
// Reset is held low for pResetCycles rising edges
//------------------------------
module ClockGen #(
	parameter int pPeriod      = 4,
	parameter int pResetCycles = 4
) (
	output logic iMCLK,
	output logic qlocked
);

	initial
	begin
		iMCLK = 1'b0;
		forever #(pPeriod / 2) iMCLK = ~iMCLK;
	end

	initial
	begin
		qlocked = 1'b0;
		repeat (pResetCycles) @(posedge iMCLK);
		qlocked <= 1'b1;
	end

endmodule

// File: tests/SynthTop_sva.sv
//------------------------------
// Concurrent checks on the APB handshake, I2S framing and the sample path
// Bound into every SynthTop instance
//------------------------------
module SynthTop_sva (
	input logic                              iMCLK,
	input logic                              qlocked,
	input logic                              PSEL,
	input logic                              PENABLE,
	input logic                              PREADY,
	input logic                              PSLVERR,
	input logic                              oI2sBclk,
	input logic                              oI2sLrclk,
	input logic                              wGate,
	input logic                              wEnable,
	input logic [SynthPkg::cVolumeWidth-1:0] wVolume,
	input logic [SynthPkg::cSampleWidth-1:0] wSample
);
	import SynthPkg::*;

	// Failures seen so far, read by the testbench summary
	int failCount = 0;

	//------------------------------
	// APB
	//------------------------------
	errWithReady: assert property (@(posedge iMCLK) disable iff (!qlocked)
		PSLVERR |-> PREADY)
	else
	begin
		failCount++;
		$error("PSLVERR high without PREADY");
	end

	readyInAccess: assert property (@(posedge iMCLK) disable iff (!qlocked)
		PREADY |-> PSEL && PENABLE)
	else
	begin
		failCount++;
		$error("PREADY high outside an access phase");
	end

	// LRCLK moves on the BCLK falling edge only
	lrclkOnFall: assert property (@(posedge iMCLK) disable iff (!qlocked)
		$changed(oI2sLrclk) |-> !oI2sBclk)
	else
	begin
		failCount++;
		$error("LRCLK changed while BCLK was high");
	end

	//------------------------------
	// Sample path
	//------------------------------
	silentWhenIdle: assert property (@(posedge iMCLK) disable iff (!qlocked)
		!(wGate && wEnable) |-> wSample == '0)
	else
	begin
		failCount++;
		$error("Sample nonzero with gate or enable low");
	end

	magnitudeIsVolume: assert property (@(posedge iMCLK) disable iff (!qlocked)
		wGate && wEnable |-> (wSample == cSampleWidth'(wVolume))
			|| (wSample == -cSampleWidth'(wVolume)))
	else
	begin
		failCount++;
		$error("Sample magnitude differs from VOLUME");
	end

endmodule

bind SynthTop SynthTop_sva SvaCheck (
	.iMCLK(iMCLK),         .qlocked(qlocked),
	.PSEL(PSEL),           .PENABLE(PENABLE),
	.PREADY(PREADY),       .PSLVERR(PSLVERR),
	.oI2sBclk(oI2sBclk),   .oI2sLrclk(oI2sLrclk),
	.wGate(wGate),         .wEnable(wEnable),
	.wVolume(wVolume),     .wSample(wSample)
);

// File: tests/SynthTb.sv
//------------------------------
// Testbench for SynthTop with APB and MIDI drivers and an I2S capture
// Runs five directed tests and prints one line each and a summary
//------------------------------
module SynthTb;
	import SynthPkg::*;

	localparam int cClkPeriod     = 4;
	localparam int cMidiClkPerBit = 32;
	localparam int cBclkHalf      = 4;
	localparam int cFrameCycles   = 64 * cBclkHalf;
	localparam int cByteTime      = 10 * cMidiClkPerBit * cClkPeriod;
	localparam int cFrameTime     = cFrameCycles * cClkPeriod;
	// About 30 MIDI bytes and 80 I2S frames in all, with 60 percent margin
	localparam int cWatchdogTime  = (30 * cByteTime + 80 * cFrameTime) * 8 / 5;

	logic        iMCLK;
	logic        qlocked;
	logic        iMidi   = 1'b1;
	logic        PSEL    = 1'b0;
	logic        PENABLE = 1'b0;
	logic        PWRITE  = 1'b0;
	logic [7:0]  PADDR   = '0;
	logic [31:0] PWDATA  = '0;
	logic [31:0] PRDATA;
	logic        PREADY;
	logic        PSLVERR;
	logic        oI2sBclk;
	logic        oI2sLrclk;
	logic        oI2sSdata;

	// I2S capture state
	logic [31:0] capShift  = '0;
	logic        capPrevLr = 1'b0;
	logic [15:0] capLeft   = '0;
	logic [15:0] capRight  = '0;
	int          frameCount = 0;

	int          seed = 28;
	int          errCount;
	int          testErrors;
	int          testCount;
	int          failedTests;
	string       testName;
	logic [31:0] data;
	logic [31:0] rdata;
	logic        slverr;
	logic [3:0]  ch;
	logic [6:0]  key;
	logic [6:0] key2;
	logic [14:0] vol;
	logic [15:0] left;
	logic [15:0] right;
	logic        posSeen;
	logic        negSeen;

	ClockGen #(.pPeriod(cClkPeriod), .pResetCycles(4)) ClockGen (
		.iMCLK(iMCLK), .qlocked(qlocked)
	);

	SynthTop #(.pMidiClkPerBit(cMidiClkPerBit), .pBclkHalf(cBclkHalf)) UUT (
		.iMCLK(iMCLK),       .qlocked(qlocked),     .iMidi(iMidi),
		.PSEL(PSEL),         .PENABLE(PENABLE),     .PWRITE(PWRITE),
		.PADDR(PADDR),       .PWDATA(PWDATA),       .PRDATA(PRDATA),
		.PREADY(PREADY),     .PSLVERR(PSLVERR),
		.oI2sBclk(oI2sBclk), .oI2sLrclk(oI2sLrclk), .oI2sSdata(oI2sSdata)
	);

	// Frame ends with the right LSB in the first slot of the next frame
	always @(posedge oI2sBclk)
	begin
		capShift = {capShift[30:0], oI2sSdata};
		if (capPrevLr && !oI2sLrclk)
		begin
			capLeft  = capShift[31:16];
			capRight = capShift[15:0];
			frameCount++;
		end
		capPrevLr = oI2sLrclk;
	end

	//------------------------------
	// Helpers
	//------------------------------
	task expectValue(input string what, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			errCount++;
			testErrors++;
			$display("[FAIL] %0t %s: got 0x%0h, expected 0x%0h", $time, what, got, exp);
		end
	endtask

	task apbAccess(input logic isWrite, input logic [7:0] adrs, input logic [31:0] wdata,
			output logic [31:0] rd, output logic err);
		int waited;
		@(posedge iMCLK);
		PSEL    <= 1'b1;
		PENABLE <= 1'b0;
		PWRITE  <= isWrite;
		PADDR   <= adrs;
		PWDATA  <= wdata;
		@(posedge iMCLK);
		PENABLE <= 1'b1;
		@(posedge iMCLK);
		waited = 1;
		while (!PREADY && waited < 8)
		begin
			@(posedge iMCLK);
			waited++;
		end
		rd  = PRDATA;
		err = PSLVERR;
		if (!PREADY)
		begin
			errCount++;
			testErrors++;
			$display("APB access to offset 0x%0h never got PREADY", adrs);
		end
		PSEL    <= 1'b0;
		PENABLE <= 1'b0;
	endtask

	// 8N1 byte, LSB first, with a chosen stop bit level
	task sendByte(input logic [7:0] value, input logic stopBit);
		logic [9:0] bits;
		bits = {stopBit, value, 1'b0};
		for (int i = 0; i < 10; i++)
		begin
			@(posedge iMCLK);
			iMidi <= bits[i];
			repeat (cMidiClkPerBit - 1) @(posedge iMCLK);
		end
		if (!stopBit)
		begin
			@(posedge iMCLK);
			iMidi <= 1'b1;
			repeat (2 * cMidiClkPerBit) @(posedge iMCLK);
		end
	endtask

	task nextFrame(output logic [15:0] l, output logic [15:0] r);
		int startCount;
		int waited;
		startCount = frameCount;
		waited     = 0;
		while (frameCount == startCount && waited < 2 * cFrameCycles)
		begin
			@(posedge iMCLK);
			waited++;
		end
		if (frameCount == startCount)
		begin
			errCount++;
			testErrors++;
			$display("No I2S frame arrived within %0d clock cycles", 2 * cFrameCycles);
		end
		l = capLeft;
		r = capRight;
	endtask

	task startTest(input string name);
		testName   = name;
		testErrors = 0;
	endtask

	task reportTest();
		testCount++;
		if (testErrors == 0)
			$display("Test %0d %s: ok", testCount, testName);
		else
		begin
			failedTests++;
			$display("Test %0d %s: %0d errors", testCount, testName, testErrors);
		end
	endtask

	//------------------------------
	// Tests
	//------------------------------
	initial
	begin
		errCount    = 0;
		testCount   = 0;
		failedTests = 0;
		@(posedge qlocked);

		startTest("reset values and register access");
		expectValue("BCLK after reset", oI2sBclk, 0);
		expectValue("LRCLK after reset", oI2sLrclk, 0);
		expectValue("SDATA after reset", oI2sSdata, 0);
		expectValue("PREADY after reset", PREADY, 0);
		expectValue("PSLVERR after reset", PSLVERR, 0);
		apbAccess(1'b0, cAdrsCtrl, 32'h0, rdata, slverr);
		expectValue("CTRL reset value", rdata, 0);
		apbAccess(1'b0, cAdrsVolume, 32'h0, rdata, slverr);
		expectValue("VOLUME reset value", rdata, 0);
		apbAccess(1'b0, cAdrsStatus, 32'h0, rdata, slverr);
		expectValue("STATUS reset value", rdata, 0);
		for (int i = 0; i < 4; i++)
		begin
			data = $random(seed);
			apbAccess(1'b1, cAdrsCtrl, data, rdata, slverr);
			expectValue("PSLVERR on CTRL write", slverr, 0);
			apbAccess(1'b0, cAdrsCtrl, 32'h0, rdata, slverr);
			expectValue("CTRL readback", rdata, data & 32'h0000_00F1);
			data = $random(seed);
			apbAccess(1'b1, cAdrsVolume, data, rdata, slverr);
			apbAccess(1'b0, cAdrsVolume, 32'h0, rdata, slverr);
			expectValue("VOLUME readback", rdata, data & 32'h0000_7FFF);
		end
		apbAccess(1'b1, 8'h10, 32'hFFFF_FFFF, rdata, slverr);
		expectValue("PSLVERR on write to 0x10", slverr, 1);
		apbAccess(1'b0, 8'h10, 32'h0, rdata, slverr);
		expectValue("PSLVERR on read of 0x10", slverr, 1);
		apbAccess(1'b1, cAdrsVolume, 32'h0, rdata, slverr);
		reportTest();

		startTest("channel filtering");
		ch  = 4'($random(seed));
		key = 7'(60 + {$random(seed)} % 13);
		apbAccess(1'b1, cAdrsCtrl, {24'h0, ch, 4'h1}, rdata, slverr);
		sendByte({4'h9, ch}, 1'b1);
		sendByte({1'b0, key}, 1'b1);
		sendByte(8'h40, 1'b1);
		apbAccess(1'b0, cAdrsStatus, 32'h0, rdata, slverr);
		expectValue("STATUS after note-on", rdata, 32'h100 | key);
		sendByte({4'h9, ch ^ 4'h5}, 1'b1);
		sendByte({1'b0, key + 7'd5}, 1'b1);
		sendByte(8'h40, 1'b1);
		apbAccess(1'b0, cAdrsStatus, 32'h0, rdata, slverr);
		expectValue("STATUS after note-on on other channel", rdata, 32'h100 | key);
		reportTest();

		startTest("note release");
		key2 = 7'(48 + {$random(seed)} % 12);
		sendByte({4'h9, ch}, 1'b1);
		sendByte({1'b0, key2}, 1'b1);
		sendByte(8'h50, 1'b1);
		apbAccess(1'b0, cAdrsStatus, 32'h0, rdata, slverr);
		expectValue("STATUS after second note-on", rdata, 32'h100 | key2);
		// Running status, velocity 0
		sendByte({1'b0, key2}, 1'b1);
		sendByte(8'h00, 1'b1);
		apbAccess(1'b0, cAdrsStatus, 32'h0, rdata, slverr);
		expectValue("STATUS after velocity 0", rdata, 32'h0 | key2);
		sendByte({4'h9, ch}, 1'b1);
		sendByte({1'b0, key}, 1'b1);
		sendByte(8'h50, 1'b1);
		sendByte({4'h8, ch}, 1'b1);
		sendByte({1'b0, key2}, 1'b1);
		sendByte(8'h40, 1'b1);
		apbAccess(1'b0, cAdrsStatus, 32'h0, rdata, slverr);
		expectValue("STATUS after note-off of other key", rdata, 32'h100 | key);
		sendByte({1'b0, key}, 1'b1);
		sendByte(8'h40, 1'b1);
		apbAccess(1'b0, cAdrsStatus, 32'h0, rdata, slverr);
		expectValue("STATUS after note-off of held key", rdata, 32'h0 | key);
		reportTest();

		startTest("audio output");
		vol = 15'($random(seed)) | 15'h0001;
		key = 7'(60 + {$random(seed)} % 13);
		apbAccess(1'b1, cAdrsVolume, {17'h0, vol}, rdata, slverr);
		sendByte({4'h9, ch}, 1'b1);
		sendByte({1'b0, key}, 1'b1);
		sendByte(8'h60, 1'b1);
		// First two frames may still hold the old sample
		nextFrame(left, right);
		nextFrame(left, right);
		posSeen = 1'b0;
		negSeen = 1'b0;
		for (int i = 0; i < 64 && !(posSeen && negSeen); i++)
		begin
			nextFrame(left, right);
			expectValue("right channel equals left", right, left);
			if (left == 16'(vol))
				posSeen = 1'b1;
			else if (left == -16'(vol))
				negSeen = 1'b1;
			else
				expectValue("sample magnitude", left, 16'(vol));
		end
		expectValue("both signs within 64 frames", {posSeen, negSeen}, 2'b11);
		apbAccess(1'b1, cAdrsCtrl, {24'h0, ch, 4'h0}, rdata, slverr);
		nextFrame(left, right);
		nextFrame(left, right);
		repeat (4)
		begin
			nextFrame(left, right);
			expectValue("left sample with enable low", left, 0);
			expectValue("right sample with enable low", right, 0);
		end
		reportTest();

		startTest("framing error");
		apbAccess(1'b0, cAdrsStatus, 32'h0, rdata, slverr);
		expectValue("STATUS before bad byte", rdata, 32'h100 | key);
		// Bad byte sits where the velocity of a note-on for key2 would be
		sendByte({4'h9, ch}, 1'b1);
		sendByte({1'b0, key2}, 1'b1);
		sendByte(8'h3C, 1'b0);
		apbAccess(1'b0, cAdrsStatus, 32'h0, rdata, slverr);
		expectValue("STATUS after bad stop bit", rdata, 32'h300 | key);
		apbAccess(1'b1, cAdrsStatus, 32'h200, rdata, slverr);
		apbAccess(1'b0, cAdrsStatus, 32'h0, rdata, slverr);
		expectValue("STATUS after error clear", rdata, 32'h100 | key);
		reportTest();

		$display("Summary: %0d tests, %0d failing, %0d check errors, %0d assertion errors",
			testCount, failedTests, errCount, UUT.SvaCheck.failCount);
		if (errCount == 0 && UUT.SvaCheck.failCount == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(cWatchdogTime);
		$display("Run timed out after %0d time units", cWatchdogTime);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// File: files.f
src/SynthPkg.sv
src/MidiRx.sv
src/MidiParser.sv
src/SynthCsr.sv
src/ToneGen.sv
src/I2sTx.sv
src/SynthTop.sv
tests/ClockGen.sv
tests/SynthTop_sva.sv
tests/SynthTb.sv
